/* common/link_pkg.sv */
package link_pkg;

    localparam int opcode_w  = 3;
    localparam int payload_w = 5;
    localparam int coord_w   = 10;      // two payload parts

    typedef enum logic [opcode_w-1:0] {
        op_sync      = 3'd0,
        op_keeper_lo = 3'd1,
        op_keeper_hi = 3'd2,
        op_shot_x_lo = 3'd3,
        op_shot_x_hi = 3'd4,
        op_shot_y_lo = 3'd5,
        op_shot_y_hi = 3'd6,
        op_score     = 3'd7
    } msg_opcode_e;

    typedef enum logic [payload_w-1:0] {
        sync_shooter_start = 5'b11001,  // peer keeps goal, we shoot
        sync_keeper_start  = 5'b01001,  // peer shoots, we keep goal
        sync_idle          = 5'b00001,
        sync_return_start  = 5'b00101   // back to start screen
    } sync_code_e;

    // op_score payload fields
    localparam int score_w    = 3;
    localparam int scored_bit = 3;
    localparam int input_bit  = 4;

    localparam int fifo_depth = 8;
    localparam int fifo_ptr_w = $clog2(fifo_depth);
    localparam int fifo_cnt_w = $clog2(fifo_depth + 1);
    localparam logic [fifo_ptr_w-1:0] fifo_last = fifo_ptr_w'(fifo_depth - 1);
    localparam logic [fifo_cnt_w-1:0] fifo_full = fifo_cnt_w'(fifo_depth);

    // credits equal the decoder queue size
    localparam int credit_init = 2;
    localparam int credit_w    = $clog2(credit_init + 1);
    localparam int q_ptr_w     = $clog2(credit_init);
    localparam logic [credit_w-1:0] credit_max = credit_w'(credit_init);
    localparam logic [q_ptr_w-1:0]  q_last     = q_ptr_w'(credit_init - 1);

    localparam int link_timeout = 4000;
    localparam int wdog_w       = $clog2(link_timeout + 1);
    localparam logic [wdog_w-1:0] wdog_limit = wdog_w'(link_timeout);

endpackage

/* common/uart_pkg.sv */
package uart_pkg;

    // serial bit timing
    localparam int clks_per_bit = 16;   // short bit time for simulation
    localparam int data_bits    = 8;
    localparam int half_bit     = clks_per_bit / 2;
    localparam int sync_lat     = 3;    // line edge to start state, in cycles

    localparam int cnt_w = $clog2(clks_per_bit);
    localparam int idx_w = $clog2(data_bits);

    // counter compare points
    localparam logic [cnt_w-1:0] mid_cnt  = cnt_w'(half_bit - 1);
    localparam logic [cnt_w-1:0] last_cnt = cnt_w'(clks_per_bit - 1);

    // stop bit is judged early to absorb the synchronizer delay
    localparam logic [cnt_w-1:0] stop_cnt = cnt_w'(clks_per_bit - 1 - sync_lat);
    localparam logic [idx_w-1:0] last_bit = idx_w'(data_bits - 1);

endpackage

/* dv/tb_game_link.sv */
`timescale 1ns/1ps

module tb_game_link;

    localparam int max_entries   = 16;
    localparam int match_timeout = 2000;   // cycles allowed for outputs to settle

    typedef struct packed {
        logic       link_ok;
        logic       enemy_shooter;
        logic       game_starts;
        logic       back_to_start;
        logic [9:0] keeper_pos;
        logic [9:0] shot_x;
        logic [9:0] shot_y;
        logic [2:0] opponent_score;
        logic       enemy_scored;
        logic       enemy_input;
        logic       rx_overflow;
    } outs_t;

    logic       clk = 1'b0;
    logic       rst;
    logic       rx;
    logic       link_ok;
    logic       enemy_shooter;
    logic       game_starts;
    logic       back_to_start;
    logic [9:0] keeper_pos;
    logic [9:0] shot_x;
    logic [9:0] shot_y;
    logic [2:0] opponent_score;
    logic       enemy_scored;
    logic       enemy_input;
    logic       rx_overflow;

    // stimulus table
    logic [7:0]  tbl_bytes [max_entries][8];
    int          tbl_len [max_entries];
    bit          tbl_bad [max_entries];
    int          tbl_gap [max_entries];
    outs_t       tbl_exp [max_entries];
    int          n_entries;
    outs_t       want;                      // running expected state
    logic [31:0] lcg_state;

    game_link_top uut (
        .clk            (clk),
        .rst            (rst),
        .rx             (rx),
        .link_ok        (link_ok),
        .enemy_shooter  (enemy_shooter),
        .game_starts    (game_starts),
        .back_to_start  (back_to_start),
        .keeper_pos     (keeper_pos),
        .shot_x         (shot_x),
        .shot_y         (shot_y),
        .opponent_score (opponent_score),
        .enemy_scored   (enemy_scored),
        .enemy_input    (enemy_input),
        .rx_overflow    (rx_overflow)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic outs_t observed();
        return {link_ok, enemy_shooter, game_starts, back_to_start, keeper_pos, shot_x,
                shot_y, opponent_score, enemy_scored, enemy_input, rx_overflow};
    endfunction

    function automatic string mismatch_name(input outs_t got, input outs_t exp);
        if (got.link_ok !== exp.link_ok) return "link_ok";
        if (got.enemy_shooter !== exp.enemy_shooter) return "enemy_shooter";
        if (got.game_starts !== exp.game_starts) return "game_starts";
        if (got.back_to_start !== exp.back_to_start) return "back_to_start";
        if (got.keeper_pos !== exp.keeper_pos) return "keeper_pos";
        if (got.shot_x !== exp.shot_x) return "shot_x";
        if (got.shot_y !== exp.shot_y) return "shot_y";
        if (got.opponent_score !== exp.opponent_score) return "opponent_score";
        if (got.enemy_scored !== exp.enemy_scored) return "enemy_scored";
        if (got.enemy_input !== exp.enemy_input) return "enemy_input";
        if (got.rx_overflow !== exp.rx_overflow) return "rx_overflow";
        return "none";
    endfunction

    task automatic check_outputs(input outs_t got, input outs_t exp);
        if (got !== exp) begin
            $display("ERR %0t: %s wrong, outputs %h expected %h", $time,
                     mismatch_name(got, exp), got, exp);
            $display("Verification failed");
            $fatal(1, "output mismatch");
        end
    endtask

    task automatic wait_outputs(input outs_t exp);
        int cycles;
        cycles = 0;
        @(negedge clk);                     // sample mid-cycle
        while (observed() !== exp && cycles < match_timeout) begin
            @(negedge clk);
            cycles++;
        end
        if (observed() !== exp) begin
            $display("timeout: %s never reached its expected value within %0d cycles",
                     mismatch_name(observed(), exp), match_timeout);
            $display("Verification failed");
            $fatal(1, "wait timed out");
        end
    endtask

    task automatic hold_line(input logic level, input int cycles);
        @(posedge clk);
        rx <= level;
        repeat (cycles - 1) @(posedge clk);
    endtask

    // 8N1, lsb first
    task automatic send_frame(input logic [7:0] data, input bit bad_stop);
        hold_line(1'b0, uart_pkg::clks_per_bit);
        for (int i = 0; i < uart_pkg::data_bits; i++) begin
            hold_line(data[i], uart_pkg::clks_per_bit);
        end
        if (bad_stop) begin
            hold_line(1'b0, uart_pkg::half_bit);   // low through the sample point
            hold_line(1'b1, uart_pkg::clks_per_bit - uart_pkg::half_bit);
        end else begin
            hold_line(1'b1, uart_pkg::clks_per_bit);
        end
    endtask

    task automatic add_byte(input logic [2:0] op, input logic [4:0] payload);
        tbl_bytes[n_entries][tbl_len[n_entries]] = {payload, op};
        tbl_len[n_entries]++;
    endtask

    task automatic close_entry(input bit bad, input int gap);
        tbl_bad[n_entries] = bad;
        tbl_gap[n_entries] = gap;
        tbl_exp[n_entries] = want;
        n_entries++;
    endtask

    task automatic set_flags(input logic ok, input logic shooter, input logic starts,
                             input logic back);
        want.link_ok       = ok;
        want.enemy_shooter = shooter;
        want.game_starts   = starts;
        want.back_to_start = back;
    endtask

    task automatic build_table();
        logic [31:0] r;
        logic [link_pkg::coord_w-1:0] kp;
        logic [link_pkg::coord_w-1:0] sx;
        logic [link_pkg::coord_w-1:0] sy;
        logic [4:0]  sc;
        want = '0;
        add_byte(link_pkg::op_sync, link_pkg::sync_shooter_start);
        set_flags(1'b1, 1'b0, 1'b1, 1'b0);
        close_entry(1'b0, 20);
        add_byte(link_pkg::op_sync, link_pkg::sync_return_start);
        set_flags(1'b1, 1'b0, 1'b0, 1'b1);
        close_entry(1'b0, 20);
        add_byte(link_pkg::op_sync, link_pkg::sync_idle);
        set_flags(1'b1, 1'b0, 1'b0, 1'b0);
        close_entry(1'b0, 20);
        add_byte(link_pkg::op_sync, link_pkg::sync_keeper_start);
        set_flags(1'b1, 1'b1, 1'b1, 1'b0);
        close_entry(1'b0, 20);
        add_byte(link_pkg::op_sync, 5'b10101);      // not a sync code
        set_flags(1'b0, 1'b0, 1'b0, 1'b0);
        close_entry(1'b0, 20);
        add_byte(link_pkg::op_sync, link_pkg::sync_keeper_start);
        set_flags(1'b1, 1'b1, 1'b1, 1'b0);
        close_entry(1'b0, 20);
        r  = lcg_next();
        kp = r[31:22];
        add_byte(link_pkg::op_keeper_lo, kp[4:0]);  // lo part alone
        close_entry(1'b0, 20);
        add_byte(link_pkg::op_keeper_hi, kp[9:5]);
        want.keeper_pos = kp;
        close_entry(1'b0, 20);
        r  = lcg_next();
        sx = r[31:22];
        r  = lcg_next();
        sy = r[31:22];
        add_byte(link_pkg::op_shot_x_lo, sx[4:0]);
        add_byte(link_pkg::op_shot_x_hi, sx[9:5]);  // x still held back
        close_entry(1'b0, 20);
        add_byte(link_pkg::op_shot_y_lo, sy[4:0]);
        close_entry(1'b0, 20);
        add_byte(link_pkg::op_shot_y_hi, sy[9:5]);
        want.shot_x = sx;
        want.shot_y = sy;
        close_entry(1'b0, 20);
        r  = lcg_next();
        sc = r[31:27];
        add_byte(link_pkg::op_score, sc);
        want.opponent_score = sc[2:0];
        want.enemy_scored   = sc[3];
        want.enemy_input    = sc[4];
        close_entry(1'b0, 20);
        add_byte(link_pkg::op_score, ~sc);          // framing error, must be dropped
        close_entry(1'b1, 400);
        set_flags(1'b0, 1'b1, 1'b1, 1'b0);          // silent peer, flags stay
        close_entry(1'b0, link_pkg::link_timeout + 100);
        r  = lcg_next();
        kp = r[31:22];
        r  = lcg_next();
        sx = r[31:22];
        sy = r[21:12];
        sc = r[11:7];
        add_byte(link_pkg::op_sync, link_pkg::sync_shooter_start);
        add_byte(link_pkg::op_keeper_lo, kp[4:0]);
        add_byte(link_pkg::op_keeper_hi, kp[9:5]);
        add_byte(link_pkg::op_shot_x_lo, sx[4:0]);
        add_byte(link_pkg::op_shot_x_hi, sx[9:5]);
        add_byte(link_pkg::op_shot_y_lo, sy[4:0]);
        add_byte(link_pkg::op_shot_y_hi, sy[9:5]);
        add_byte(link_pkg::op_score, sc);           // eight frames back to back
        set_flags(1'b1, 1'b0, 1'b1, 1'b0);
        want.keeper_pos     = kp;
        want.shot_x         = sx;
        want.shot_y         = sy;
        want.opponent_score = sc[2:0];
        want.enemy_scored   = sc[3];
        want.enemy_input    = sc[4];
        close_entry(1'b0, 20);
    endtask

    initial begin
        rst       = 1'b1;
        rx        = 1'b1;                   // line idles high
        lcg_state = 32'h6b3b_fe35;
        n_entries = 0;
        for (int i = 0; i < max_entries; i++) begin
            tbl_len[i] = 0;
        end
        build_table();
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_outputs(observed(), '0);
        for (int e = 0; e < n_entries; e++) begin
            for (int b = 0; b < tbl_len[e]; b++) begin
                send_frame(tbl_bytes[e][b], tbl_bad[e]);
            end
            repeat (tbl_gap[e]) @(posedge clk);
            wait_outputs(tbl_exp[e]);
            repeat (2) @(negedge clk);      // must hold, not just pass through
            check_outputs(observed(), tbl_exp[e]);
        end
        $display("Verification passed");
        $finish;
    end

endmodule

/* hdl/game_link_top.sv */
`timescale 1ns/1ps

module game_link_top (
    input  logic       clk,
    input  logic       rst,
    input  logic       rx,
    output logic       link_ok,
    output logic       enemy_shooter,
    output logic       game_starts,
    output logic       back_to_start,
    output logic [9:0] keeper_pos,
    output logic [9:0] shot_x,
    output logic [9:0] shot_y,
    output logic [2:0] opponent_score,
    output logic       enemy_scored,
    output logic       enemy_input,
    output logic       rx_overflow
);

    logic       byte_valid;
    logic [7:0] byte_data;
    logic       msg_valid;
    logic [7:0] msg_data;
    logic       msg_credit;

    uart_rx u_uart_rx (
        .clk        (clk),
        .rst        (rst),
        .rx         (rx),
        .byte_valid (byte_valid),
        .byte_data  (byte_data)
    );

    rx_fifo u_rx_fifo (
        .clk         (clk),
        .rst         (rst),
        .byte_valid  (byte_valid),
        .byte_data   (byte_data),
        .msg_valid   (msg_valid),
        .msg_data    (msg_data),
        .msg_credit  (msg_credit),
        .rx_overflow (rx_overflow)
    );

    link_decoder u_link_decoder (
        .clk            (clk),
        .rst            (rst),
        .msg_valid      (msg_valid),
        .msg_data       (msg_data),
        .msg_credit     (msg_credit),
        .link_ok        (link_ok),
        .enemy_shooter  (enemy_shooter),
        .game_starts    (game_starts),
        .back_to_start  (back_to_start),
        .keeper_pos     (keeper_pos),
        .shot_x         (shot_x),
        .shot_y         (shot_y),
        .opponent_score (opponent_score),
        .enemy_scored   (enemy_scored),
        .enemy_input    (enemy_input)
    );

endmodule

/* hdl/link_decoder.sv */
`timescale 1ns/1ps

module link_decoder (
    input  logic       clk,
    input  logic       rst,
    input  logic       msg_valid,
    input  logic [7:0] msg_data,
    output logic       msg_credit,
    output logic       link_ok,
    output logic       enemy_shooter,
    output logic       game_starts,
    output logic       back_to_start,
    output logic [9:0] keeper_pos,
    output logic [9:0] shot_x,
    output logic [9:0] shot_y,
    output logic [2:0] opponent_score,
    output logic       enemy_scored,
    output logic       enemy_input
);

    logic [7:0] q_mem [link_pkg::credit_init];
    logic [link_pkg::q_ptr_w-1:0] q_wr;
    logic [link_pkg::q_ptr_w-1:0] q_rd;
    logic [link_pkg::credit_w-1:0] q_cnt;
    logic pop;
    logic [7:0] head;
    link_pkg::msg_opcode_e opcode;
    link_pkg::sync_code_e sync_code;
    logic [link_pkg::payload_w-1:0] payload;
    logic [link_pkg::payload_w-1:0] keeper_lo;
    logic [link_pkg::payload_w-1:0] shot_x_lo;
    logic [link_pkg::payload_w-1:0] shot_x_hi;
    logic [link_pkg::payload_w-1:0] shot_y_lo;
    logic [link_pkg::wdog_w-1:0] wdog_cnt;

    assign pop        = (q_cnt != '0);   // one byte per cycle
    assign msg_credit = pop;
    assign head       = q_mem[q_rd];
    assign opcode     = link_pkg::msg_opcode_e'(head[link_pkg::opcode_w-1:0]);
    assign payload    = head[link_pkg::opcode_w +: link_pkg::payload_w];
    assign sync_code  = link_pkg::sync_code_e'(payload);

    always_ff @(posedge clk) begin
        if (msg_valid) begin
            q_mem[q_wr] <= msg_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            q_wr  <= '0;
            q_rd  <= '0;
            q_cnt <= '0;
        end else begin
            if (msg_valid) begin
                q_wr <= (q_wr == link_pkg::q_last) ? '0 : q_wr + 1'b1;
            end
            if (pop) begin
                q_rd <= (q_rd == link_pkg::q_last) ? '0 : q_rd + 1'b1;
            end
            case ({msg_valid, pop})
                2'b10:   q_cnt <= q_cnt + 1'b1;
                2'b01:   q_cnt <= q_cnt - 1'b1;
                default: q_cnt <= q_cnt;
            endcase
        end
    end

    // low parts wait here until the closing message
    always_ff @(posedge clk) begin
        if (pop) begin
            case (opcode)
                link_pkg::op_keeper_lo: keeper_lo <= payload;
                link_pkg::op_shot_x_lo: shot_x_lo <= payload;
                link_pkg::op_shot_x_hi: shot_x_hi <= payload;
                link_pkg::op_shot_y_lo: shot_y_lo <= payload;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            link_ok        <= 1'b0;
            enemy_shooter  <= 1'b0;
            game_starts    <= 1'b0;
            back_to_start  <= 1'b0;
            keeper_pos     <= '0;
            shot_x         <= '0;
            shot_y         <= '0;
            opponent_score <= '0;
            enemy_scored   <= 1'b0;
            enemy_input    <= 1'b0;
        end else if (pop) begin
            case (opcode)
                link_pkg::op_sync: begin
                    link_ok       <= 1'b1;
                    enemy_shooter <= (sync_code == link_pkg::sync_keeper_start);
                    game_starts   <= (sync_code == link_pkg::sync_keeper_start) ||
                                     (sync_code == link_pkg::sync_shooter_start);
                    back_to_start <= (sync_code == link_pkg::sync_return_start);
                    case (sync_code)
                        link_pkg::sync_shooter_start,
                        link_pkg::sync_keeper_start,
                        link_pkg::sync_idle,
                        link_pkg::sync_return_start: ;
                        default: link_ok <= 1'b0;   // garbage sync means a broken link
                    endcase
                end
                link_pkg::op_keeper_hi: keeper_pos <= {payload, keeper_lo};
                link_pkg::op_shot_y_hi: begin
                    shot_x <= {shot_x_hi, shot_x_lo};    // x and y land together
                    shot_y <= {payload, shot_y_lo};
                end
                link_pkg::op_score: begin
                    opponent_score <= payload[link_pkg::score_w-1:0];
                    enemy_scored   <= payload[link_pkg::scored_bit];
                    enemy_input    <= payload[link_pkg::input_bit];
                end
                default: ;
            endcase
        end else if (wdog_cnt == link_pkg::wdog_limit) begin
            link_ok <= 1'b0;                             // silent peer
        end
    end

    always_ff @(posedge clk) begin
        if (rst || pop) begin
            wdog_cnt <= '0;
        end else if (wdog_cnt != link_pkg::wdog_limit) begin
            wdog_cnt <= wdog_cnt + 1'b1;                 // saturates at the limit
        end
    end

    // fifo must hold back while every queue slot is taken
    queue_no_overflow: assert property (@(posedge clk) disable iff (rst)
        msg_valid |-> (q_cnt != link_pkg::credit_max));

endmodule

/* hdl/rx_fifo.sv */
`timescale 1ns/1ps

module rx_fifo (
    input  logic       clk,
    input  logic       rst,
    input  logic       byte_valid,
    input  logic [7:0] byte_data,
    output logic       msg_valid,
    output logic [7:0] msg_data,
    input  logic       msg_credit,
    output logic       rx_overflow
);

    logic [7:0] mem [link_pkg::fifo_depth];
    logic [link_pkg::fifo_ptr_w-1:0] wr_ptr;
    logic [link_pkg::fifo_ptr_w-1:0] rd_ptr;
    logic [link_pkg::fifo_cnt_w-1:0] count;
    logic [link_pkg::credit_w-1:0] credits;
    logic full;
    logic push;

    assign full      = (count == link_pkg::fifo_full);
    assign push      = byte_valid && !full;
    assign msg_valid = (count != '0) && (credits != '0); // send only with a credit in hand
    assign msg_data  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= byte_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            credits     <= link_pkg::credit_max;
            rx_overflow <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == link_pkg::fifo_last) ? '0 : wr_ptr + 1'b1;
            end
            if (msg_valid) begin
                rd_ptr <= (rd_ptr == link_pkg::fifo_last) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, msg_valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            case ({msg_credit, msg_valid})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;   // send and return cancel
            endcase
            if (byte_valid && full) begin
                rx_overflow <= 1'b1;           // sticky until reset
            end
        end
    end

    // decoder never returns more credits than it was given
    credit_bound: assert property (@(posedge clk) disable iff (rst)
        credits <= link_pkg::credit_max);

endmodule

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_game_link -f src.f -o sim_tb \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || echo "build or simulation did not complete"
[ -f sim.log ] && cat sim.log
grep -qx "Verification passed" sim.log 2>/dev/null \
    && echo "RESULT: PASS" \
    || { echo "RESULT: FAIL"; exit 1; }

/* src.f */
common/uart_pkg.sv
common/link_pkg.sv
uart/uart_rx.sv
hdl/rx_fifo.sv
hdl/link_decoder.sv
hdl/game_link_top.sv
dv/tb_game_link.sv

/* uart/uart_rx.sv */
`timescale 1ns/1ps

module uart_rx (
    input  logic       clk,
    input  logic       rst,
    input  logic       rx,
    output logic       byte_valid,
    output logic [7:0] byte_data
);

    typedef enum logic [1:0] {
        st_idle,
        st_start,
        st_data,
        st_stop
    } rx_state_e;

    rx_state_e state;
    logic rx_meta;
    logic rx_s;
    logic [uart_pkg::cnt_w-1:0] cnt;
    logic [uart_pkg::idx_w-1:0] bit_idx;

    always_ff @(posedge clk) begin
        if (rst) begin
            rx_meta <= 1'b1;                // line idles high
            rx_s    <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_s    <= rx_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= st_idle;
            cnt        <= '0;
            bit_idx    <= '0;
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            case (state)
                st_idle: begin
                    cnt     <= '0;
                    bit_idx <= '0;
                    if (!rx_s) begin
                        state <= st_start;
                    end
                end
                st_start: begin
                    if (cnt == uart_pkg::mid_cnt) begin
                        cnt   <= '0;
                        state <= rx_s ? st_idle : st_data; // glitch, not a start bit
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                st_data: begin
                    if (cnt == uart_pkg::last_cnt) begin
                        cnt       <= '0;
                        byte_data <= {rx_s, byte_data[7:1]}; // lsb first
                        bit_idx   <= bit_idx + 1'b1;
                        if (bit_idx == uart_pkg::last_bit) begin
                            state <= st_stop;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: begin
                    if (cnt == uart_pkg::stop_cnt) begin
                        byte_valid <= rx_s;         // bad stop bit drops the byte
                        state      <= st_idle;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
            endcase
        end
    end

endmodule
